/* logic/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // major opcodes that end sequential fetch
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;

  // fence.i with rd, rs1 and imm all zero
  localparam logic [31:0] INST_FENCE_I = 32'h0000100f;

  // what predecode reports per fetched word
  typedef enum logic [1:0] {
    CLASS_SEQ,
    CLASS_JUMP,
    CLASS_BRANCH,
    CLASS_FENCE
  } inst_class_e;

endpackage

`default_nettype wire

/* logic/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam logic [31:0] PC_RESET = 32'h00000000;

  // 4 lines of 2 words
  localparam int IDX_W      = 2;
  localparam int LINE_WORDS = 2;

  // pc bits above index and line offset
  localparam int TAG_W = 32 - IDX_W - 3;

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_WORD0,
    RF_WORD1
  } refill_e;

endpackage

`default_nettype wire

/* logic/fetch_pc_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 accept_i,
  input  isa_pkg::inst_class_e accept_class_i,
  input  logic                 resolve_i,
  input  logic                 taken_i,
  input  logic [31:0]          target_i,
  output logic [31:0]          fetch_pc_o,
  output logic                 fetch_req_o
);

  logic [31:0] pc_q;
  logic        req_q;
  logic        stalled_q;
  logic [31:0] pc_plus4;

  assign pc_plus4 = pc_q + 32'd4;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc_q      <= fetch_pkg::PC_RESET;
      req_q     <= 1'b0;
      stalled_q <= 1'b0;
    end else begin
      if (stalled_q && resolve_i) begin
        // pc still points at the control word
        if (taken_i) begin
          pc_q <= target_i;
        end else begin
          pc_q <= pc_plus4;
        end
        stalled_q <= 1'b0;
        req_q     <= 1'b1;
      end else if (accept_i) begin
        if (accept_class_i == isa_pkg::CLASS_SEQ) begin
          pc_q <= pc_plus4;
        end else begin
          // wait for the back end
          stalled_q <= 1'b1;
          req_q     <= 1'b0;
        end
      end else if (!stalled_q) begin
        // first request after reset
        req_q <= 1'b1;
      end
    end
  end

  assign fetch_pc_o  = pc_q;
  assign fetch_req_o = req_q;

endmodule

`default_nettype wire

/* logic/fetch_icache.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_icache (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] fetch_pc_i,
  input  logic        fetch_req_i,
  input  logic        flush_i,
  output logic        hit_o,
  output logic [31:0] hit_word_o,
  output logic [31:0] mem_araddr_o,
  output logic        mem_arvalid_o,
  input  logic [31:0] mem_rdata_i,
  input  logic        mem_rvalid_i
);

  // line storage
  logic [2**fetch_pkg::IDX_W-1:0] valid_q;
  logic [fetch_pkg::TAG_W-1:0]    tag_mem  [0:2**fetch_pkg::IDX_W-1];
  logic [31:0] data_mem [0:2**fetch_pkg::IDX_W-1][0:fetch_pkg::LINE_WORDS-1];

  // lookup fields of the fetch pc
  logic [fetch_pkg::TAG_W-1:0] pc_tag;
  logic [fetch_pkg::IDX_W-1:0] pc_idx;
  logic                        pc_ofs;

  // refill bookkeeping
  fetch_pkg::refill_e                          state_q;
  logic                                        arvalid_q;
  logic                                        flush_pend_q;
  logic [fetch_pkg::TAG_W+fetch_pkg::IDX_W-1:0] line_q;
  logic [fetch_pkg::TAG_W-1:0]                 line_tag;
  logic [fetch_pkg::IDX_W-1:0]                 line_idx;
  logic                                        miss;

  assign pc_tag = fetch_pc_i[31 -: fetch_pkg::TAG_W];
  assign pc_idx = fetch_pc_i[3 +: fetch_pkg::IDX_W];
  assign pc_ofs = fetch_pc_i[2];

  assign line_tag = line_q[fetch_pkg::TAG_W+fetch_pkg::IDX_W-1:fetch_pkg::IDX_W];
  assign line_idx = line_q[fetch_pkg::IDX_W-1:0];

  assign hit_o = fetch_req_i && valid_q[pc_idx] && (tag_mem[pc_idx] == pc_tag);
  assign hit_word_o = data_mem[pc_idx][pc_ofs];

  assign miss = fetch_req_i && !hit_o && (state_q == fetch_pkg::RF_IDLE);

  // word 0 first, then word 1 of the same line
  assign mem_araddr_o  = {line_q, (state_q == fetch_pkg::RF_WORD1), 2'b00};
  assign mem_arvalid_o = arvalid_q;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q      <= fetch_pkg::RF_IDLE;
      arvalid_q    <= 1'b0;
      flush_pend_q <= 1'b0;
      valid_q      <= '0;
    end else begin
      case (state_q)
        fetch_pkg::RF_IDLE: begin
          if (miss) begin
            state_q          <= fetch_pkg::RF_WORD0;
            arvalid_q        <= 1'b1;
            // victim is overwritten word by word
            valid_q[pc_idx]  <= 1'b0;
          end
        end
        fetch_pkg::RF_WORD0: begin
          if (mem_rvalid_i) begin
            state_q   <= fetch_pkg::RF_WORD1;
            arvalid_q <= 1'b0;
          end
        end
        fetch_pkg::RF_WORD1: begin
          if (mem_rvalid_i) begin
            state_q   <= fetch_pkg::RF_IDLE;
            arvalid_q <= 1'b0;
            if (!flush_pend_q) begin
              valid_q[line_idx] <= 1'b1;
            end
          end else begin
            // re-raise after the word 0 gap
            arvalid_q <= 1'b1;
          end
        end
        default: begin
          state_q   <= fetch_pkg::RF_IDLE;
          arvalid_q <= 1'b0;
        end
      endcase

      if (state_q == fetch_pkg::RF_IDLE) begin
        flush_pend_q <= 1'b0;
      end else if (flush_i) begin
        flush_pend_q <= 1'b1;
      end

      // invalidate wins over a same-cycle line fill
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (miss) begin
      line_q <= fetch_pc_i[31:3];
    end
    if ((state_q == fetch_pkg::RF_WORD0) && mem_rvalid_i) begin
      data_mem[line_idx][0] <= mem_rdata_i;
    end
    if ((state_q == fetch_pkg::RF_WORD1) && mem_rvalid_i) begin
      data_mem[line_idx][1] <= mem_rdata_i;
      tag_mem[line_idx]     <= line_tag;
    end
  end

endmodule

`default_nettype wire

/* logic/fetch_predecode.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_predecode (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 hit_i,
  input  logic [31:0]          hit_word_i,
  input  logic [31:0]          fetch_pc_i,
  input  logic                 ready_i,
  output logic                 accept_o,
  output isa_pkg::inst_class_e accept_class_o,
  output logic                 flush_o,
  output logic [31:0]          inst_o,
  output logic [31:0]          pc_o,
  output logic                 valid_o
);

  logic [6:0]           opcode;
  isa_pkg::inst_class_e word_class;
  logic                 hold_valid_q;
  logic [31:0]          inst_q;
  logic [31:0]          pc_q;

  assign opcode = hit_word_i[6:0];

  always_comb begin
    word_class = isa_pkg::CLASS_SEQ;
    case (opcode)
      isa_pkg::OP_JAL,
      isa_pkg::OP_JALR: begin
        word_class = isa_pkg::CLASS_JUMP;
      end
      isa_pkg::OP_BRANCH: begin
        word_class = isa_pkg::CLASS_BRANCH;
      end
      isa_pkg::OP_MISC_MEM: begin
        // plain fence runs on as a sequential word
        if (hit_word_i == isa_pkg::INST_FENCE_I) begin
          word_class = isa_pkg::CLASS_FENCE;
        end
      end
      default: begin
        word_class = isa_pkg::CLASS_SEQ;
      end
    endcase
  end

  // take a new word when empty or draining this cycle
  assign accept_o       = hit_i && (!hold_valid_q || ready_i);
  assign accept_class_o = word_class;
  assign flush_o        = accept_o && (word_class == isa_pkg::CLASS_FENCE);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hold_valid_q <= 1'b0;
    end else if (accept_o) begin
      hold_valid_q <= 1'b1;
    end else if (ready_i) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept_o) begin
      inst_q <= hit_word_i;
      pc_q   <= fetch_pc_i;
    end
  end

  assign inst_o  = inst_q;
  assign pc_o    = pc_q;
  assign valid_o = hold_valid_q;

endmodule

`default_nettype wire

/* logic/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_top (
  input  logic        clk,
  input  logic        rst,
  // memory read port
  output logic [31:0] mem_araddr_o,
  output logic        mem_arvalid_o,
  input  logic [31:0] mem_rdata_i,
  input  logic        mem_rvalid_i,
  // back end outcome
  input  logic        resolve_i,
  input  logic        taken_i,
  input  logic [31:0] target_i,
  // toward decode
  output logic [31:0] inst_o,
  output logic [31:0] pc_o,
  output logic        valid_o,
  input  logic        ready_i
);

  logic [31:0]          fetch_pc;
  logic                 fetch_req;
  logic                 hit;
  logic [31:0]          hit_word;
  logic                 accept;
  isa_pkg::inst_class_e accept_class;
  logic                 flush;

  fetch_pc_gen u_pc_gen (
    .clk            (clk),
    .rst            (rst),
    .accept_i       (accept),
    .accept_class_i (accept_class),
    .resolve_i      (resolve_i),
    .taken_i        (taken_i),
    .target_i       (target_i),
    .fetch_pc_o     (fetch_pc),
    .fetch_req_o    (fetch_req)
  );

  fetch_icache u_icache (
    .clk           (clk),
    .rst           (rst),
    .fetch_pc_i    (fetch_pc),
    .fetch_req_i   (fetch_req),
    .flush_i       (flush),
    .hit_o         (hit),
    .hit_word_o    (hit_word),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i)
  );

  fetch_predecode u_predecode (
    .clk            (clk),
    .rst            (rst),
    .hit_i          (hit),
    .hit_word_i     (hit_word),
    .fetch_pc_i     (fetch_pc),
    .ready_i        (ready_i),
    .accept_o       (accept),
    .accept_class_o (accept_class),
    .flush_o        (flush),
    .inst_o         (inst_o),
    .pc_o           (pc_o),
    .valid_o        (valid_o)
  );

endmodule

`default_nettype wire

/* dv/fetch_bus_mem.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_bus_mem (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o
);

  // filled and rewritten by the testbench
  logic [31:0] words [0:255];

  logic       busy_q;
  logic [1:0] wait_q;
  logic [7:0] addr_q;

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q   <= 1'b0;
      wait_q   <= 2'd0;
      addr_q   <= 8'd0;
      rvalid_o <= 1'b0;
      rdata_o  <= 32'h0;
    end else begin
      rvalid_o <= 1'b0;
      if (busy_q) begin
        if (wait_q == 2'd0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= words[addr_q];
          busy_q   <= 1'b0;
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end else if (arvalid_i && !rvalid_o) begin
        // answer after 1 to 4 cycles
        busy_q <= 1'b1;
        wait_q <= 2'($urandom_range(3, 0));
        addr_q <= araddr_i[9:2];
      end
    end
  end

endmodule

`default_nettype wire

/* dv/fetch_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_chk (
  input logic        clk,
  input logic        rst,
  input logic        arvalid_i,
  input logic [31:0] araddr_i,
  input logic        rvalid_i,
  input logic        valid_i,
  input logic        ready_i,
  input logic [31:0] inst_i,
  input logic [31:0] pc_i
);

  int unsigned fail_cnt = 0;

  // request stays up with a fixed address until its word returns
  addr_stable: assert property (@(posedge clk) disable iff (rst)
    (arvalid_i && !rvalid_i) |=> (arvalid_i && $stable(araddr_i)))
    else begin
      $error("read address or request changed before rvalid");
      fail_cnt++;
    end

  out_hold: assert property (@(posedge clk) disable iff (rst)
    (valid_i && !ready_i) |=> (valid_i && $stable(inst_i) && $stable(pc_i)))
    else begin
      $error("decode output changed while stalled");
      fail_cnt++;
    end

  reset_idle: assert property (@(posedge clk) $fell(rst) |-> !valid_i)
    else begin
      $error("valid high right after reset");
      fail_cnt++;
    end

endmodule

bind fetch_icache fetch_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .arvalid_i (mem_arvalid_o),
  .araddr_i  (mem_araddr_o),
  .rvalid_i  (mem_rvalid_i),
  .valid_i   (1'b0),
  .ready_i   (1'b1),
  .inst_i    (32'h0),
  .pc_i      (32'h0)
);

bind fetch_predecode fetch_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .arvalid_i (1'b0),
  .araddr_i  (32'h0),
  .rvalid_i  (1'b0),
  .valid_i   (valid_o),
  .ready_i   (ready_i),
  .inst_i    (inst_o),
  .pc_i      (pc_o)
);

`default_nettype wire

/* dv/fetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_tb;

  localparam int CLK_HALF      = 4;
  localparam int MEM_WORDS     = 256;
  localparam int N_CTRL_STREAM = 40;
  localparam int N_CTRL_FENCE  = 8;
  // generous guess at words per control word
  localparam int EXP_WORDS     = (N_CTRL_STREAM + N_CTRL_FENCE + 2) * 8;
  localparam int WATCHDOG_CYC  = 400 * EXP_WORDS;

  logic        clk;
  logic        rst;
  logic [31:0] mem_araddr;
  logic        mem_arvalid;
  logic [31:0] mem_rdata;
  logic        mem_rvalid;
  logic        resolve;
  logic        taken;
  logic [31:0] target;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        valid;
  logic        ready;

  // reference model state
  logic [31:0] exp_pc;
  logic [31:0] ctrl_pc;
  logic        mir_valid [0:3];
  logic [26:0] mir_tag   [0:3];
  int          exp_lines;
  int          line_reqs = 0;
  int          n_checks;
  int          n_errors;
  logic        arvalid_d = 1'b0;

  fetch_top uut (
    .clk           (clk),
    .rst           (rst),
    .mem_araddr_o  (mem_araddr),
    .mem_arvalid_o (mem_arvalid),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid),
    .resolve_i     (resolve),
    .taken_i       (taken),
    .target_i      (target),
    .inst_o        (inst),
    .pc_o          (pc),
    .valid_o       (valid),
    .ready_i       (ready)
  );

  fetch_bus_mem mem_u (
    .clk       (clk),
    .rst       (rst),
    .araddr_i  (mem_araddr),
    .arvalid_i (mem_arvalid),
    .rdata_o   (mem_rdata),
    .rvalid_o  (mem_rvalid)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // decode side stalls about a quarter of the time
  initial begin
    ready <= 1'b0;
    forever begin
      @(posedge clk);
      ready <= !rst && ($urandom_range(3, 0) != 0);
    end
  end

  // one word 0 request per line fill
  always @(posedge clk) begin
    if (!rst && mem_arvalid && !arvalid_d && !mem_araddr[2]) begin
      line_reqs++;
    end
    arvalid_d = mem_arvalid;
  end

  initial begin
    #(WATCHDOG_CYC * 2 * CLK_HALF);
    $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
    $display("TEST FAILED");
    $finish;
  end

  task automatic check_val(input string test, input string what,
                           input logic [31:0] expected, input logic [31:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", test, what, expected, actual);
    end
  endtask

  // mostly plain words, some jal, jalr, branch and fence.i
  function automatic logic [31:0] make_word();
    int unsigned pick;
    logic [31:0] r;
    pick = $urandom_range(99, 0);
    r    = $urandom();
    if (pick < 8) begin
      return {r[31:7], isa_pkg::OP_JAL};
    end else if (pick < 15) begin
      return {r[31:7], isa_pkg::OP_JALR};
    end else if (pick < 25) begin
      return {r[31:7], isa_pkg::OP_BRANCH};
    end else if (pick < 30) begin
      return isa_pkg::INST_FENCE_I;
    end else if (pick < 65) begin
      return {r[31:7], 7'b0010011};
    end
    return {r[31:7], 7'b0110011};
  endfunction

  function automatic logic [31:0] rand_target();
    return {22'd0, 8'($urandom_range(MEM_WORDS - 1, 0)), 2'b00};
  endfunction

  task automatic mirror_access(input logic [31:0] a);
    logic [1:0] idx;
    idx = a[4:3];
    if (!mir_valid[idx] || (mir_tag[idx] != a[31:5])) begin
      exp_lines++;
      mir_valid[idx] = 1'b1;
      mir_tag[idx]   = a[31:5];
    end
  endtask

  task automatic wait_transfer();
    @(posedge clk);
    while (!(valid && ready)) begin
      @(posedge clk);
    end
  endtask

  task automatic take_word(input string test, output logic is_ctrl);
    logic [31:0] w;
    logic [6:0]  op;
    int          i;
    w  = mem_u.words[exp_pc[9:2]];
    op = w[6:0];
    check_val(test, "pc", exp_pc, pc);
    check_val(test, "inst", w, inst);
    mirror_access(exp_pc);
    is_ctrl = (op == isa_pkg::OP_JAL) || (op == isa_pkg::OP_JALR) ||
              (op == isa_pkg::OP_BRANCH) || (w == isa_pkg::INST_FENCE_I);
    if (w == isa_pkg::INST_FENCE_I) begin
      for (i = 0; i < 4; i++) begin
        mir_valid[i] = 1'b0;
      end
    end
    if (is_ctrl) begin
      ctrl_pc = exp_pc;
    end else begin
      exp_pc = exp_pc + 32'd4;
    end
  endtask

  // back end answers a few cycles after the control word
  task automatic resolve_ctrl(input string test, input logic tk, input logic [31:0] tgt);
    int gap;
    int i;
    gap = $urandom_range(6, 1);
    for (i = 0; i <= gap; i++) begin
      @(posedge clk);
      if (valid && ready) begin
        n_errors++;
        $display("%s: word at pc %h went to decode before the resolve", test, pc);
      end
      if (i == gap - 1) begin
        resolve <= 1'b1;
        taken   <= tk;
        target  <= tgt;
      end
    end
    resolve <= 1'b0;
    exp_pc = tk ? tgt : ctrl_pc + 32'd4;
  endtask

  // ends stalled on the last control word, with no refill in flight
  task automatic run_stream(input string test, input int n_ctrl);
    int   seen;
    logic c;
    seen = 0;
    while (seen < n_ctrl) begin
      wait_transfer();
      take_word(test, c);
      if (c) begin
        seen++;
        if (seen < n_ctrl) begin
          resolve_ctrl(test, 1'($urandom_range(1, 0)), rand_target());
        end
      end
    end
  endtask

  task automatic fence_reload();
    logic [31:0] base;
    logic [31:0] fence_pc;
    logic [31:0] reload_pc;
    int          i;
    reload_pc = {22'd0, ctrl_pc[9:3], 3'b000};
    // new contents behind every resident line
    for (i = 0; i < 4; i++) begin
      if (mir_valid[i]) begin
        base = {mir_tag[i], 2'(i), 3'b000};
        mem_u.words[{base[9:3], 1'b0}] = make_word();
        mem_u.words[{base[9:3], 1'b1}] = make_word();
        reload_pc = {22'd0, base[9:3], 3'b000};
      end
    end
    fence_pc = rand_target();
    while (mir_valid[fence_pc[4:3]] && (mir_tag[fence_pc[4:3]] == fence_pc[31:5])) begin
      fence_pc = rand_target();
    end
    mem_u.words[fence_pc[9:2]] = isa_pkg::INST_FENCE_I;
    resolve_ctrl("fence_reload", 1'b1, fence_pc);
    run_stream("fence_reload", 1);
    resolve_ctrl("fence_reload", 1'b1, reload_pc);
    run_stream("fence_reload", N_CTRL_FENCE);
    check_val("fence_reload", "line fills", exp_lines, line_reqs);
  endtask

  initial begin
    int t_err;
    int i;
    void'($urandom(32'h01849085));
    rst     <= 1'b1;
    resolve <= 1'b0;
    taken   <= 1'b0;
    target  <= 32'h0;
    for (i = 0; i < MEM_WORDS; i++) begin
      mem_u.words[i] = make_word();
    end
    for (i = 0; i < 4; i++) begin
      mir_valid[i] = 1'b0;
      mir_tag[i]   = 27'd0;
    end
    exp_pc    = fetch_pkg::PC_RESET;
    ctrl_pc   = 32'h0;
    exp_lines = 0;
    n_checks  = 0;
    n_errors  = 0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    t_err = n_errors;
    run_stream("seq_stream", N_CTRL_STREAM);
    check_val("seq_stream", "line fills", exp_lines, line_reqs);
    $display("test seq_stream finished with %0d errors", n_errors - t_err);

    t_err = n_errors;
    fence_reload();
    $display("test fence_reload finished with %0d errors", n_errors - t_err);

    n_errors += uut.u_icache.u_chk.fail_cnt + uut.u_predecode.u_chk.fail_cnt;
    $display("tests 2, checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/fetch_icache.sv
logic/fetch_predecode.sv
logic/fetch_top.sv
dv/fetch_bus_mem.sv
dv/fetch_chk.sv
dv/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the fetch testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f verilog.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
